// File: filelist.f
source/mem2Pkg.sv
source/dataRam.sv
source/memIssue.sv
source/mem2Queue.sv
source/mem2Writeback.sv
source/topMem2.sv
tests/topMem2_checker.sv
tests/tbTopMem2.sv

// File: source/dataRam.sv
`timescale 1ns/10ps
`default_nettype none

// word addressed data memory, registered read
module dataRam import mem2Pkg::*; #(
    parameter int RAM_WORDS = 256
) (
    input  wire logic              clk,
    input  wire logic              rstN,
    input  wire logic              ramEn,
    input  wire logic              ramWe,
    input  wire logic [ADDR_W-1:0] ramAddr,
    input  wire logic [DATA_W-1:0] ramWdata,
    output logic      [DATA_W-1:0] ramRdata
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    // storage, no reset on the array
    logic [DATA_W-1:0] mem [RAM_WORDS];
    logic [IDX_W-1:0]  wordIdx;

    // byte address -> word index, drop bits 1:0
    assign wordIdx = ramAddr[IDX_W+1:2];

    // full word store, read port untouched on a write
    always_ff @(posedge clk) begin
        if (ramEn && ramWe) begin
            mem[wordIdx] <= ramWdata;
        end
    end

    // read data holds until the next enabled read
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ramRdata <= '0;
        end else if (ramEn && !ramWe) begin
            ramRdata <= mem[wordIdx];
        end
    end

endmodule

`default_nettype wire

// File: source/mem2Pkg.sv
`default_nettype none

// shared widths and encodings for the MEM2 stage
package mem2Pkg;

    // datapath word width
    parameter int DATA_W = 32;

    // byte address width, one full data word
    parameter int ADDR_W = DATA_W;

    // register file index, 32 architectural registers
    parameter int DST_W = 5;

    // writeback source select
    typedef enum logic [1:0] {
        // link address for jal / jalr
        WB_PC8  = 2'd0,
        // plain alu result
        WB_ALU  = 2'd1,
        // second operand, move-to style ops
        WB_OUTB = 2'd2,
        // extended load data
        WB_MEM  = 2'd3
    } WbSelT;

    // load extension rule, little endian
    typedef enum logic [2:0] {
        // full word, untouched
        LD_W  = 3'd0,
        // byte at addr[1:0], sign extended
        LD_B  = 3'd1,
        // byte at addr[1:0], zero extended
        LD_BU = 3'd2,
        // halfword at addr[1], sign extended
        LD_H  = 3'd3,
        // halfword at addr[1], zero extended
        LD_HU = 3'd4
    } LoadTypeT;

endpackage

`default_nettype wire

// File: source/mem2Queue.sv
`timescale 1ns/10ps
`default_nettype none

// MEM2 register as a small in-order circular buffer
module mem2Queue import mem2Pkg::*; #(
    parameter int DEPTH = 4
) (
    input  wire logic              clk,
    input  wire logic              rstN,
    input  wire logic              mem2Flush,
    input  wire logic              push,
    input  wire logic [DATA_W-1:0] pushAluOut,
    input  wire logic [DATA_W-1:0] pushPc,
    input  wire logic [DATA_W-1:0] pushOutB,
    input  wire logic [DST_W-1:0]  pushDst,
    input  wire WbSelT             pushWbSel,
    input  wire LoadTypeT          pushLoadType,
    input  wire logic              pushRegWr,
    input  wire logic [DATA_W-1:0] pushDmOut,
    input  wire logic              pop,
    output logic                   headValid,
    output logic      [DATA_W-1:0] headAluOut,
    output logic      [DATA_W-1:0] headPc,
    output logic      [DATA_W-1:0] headOutB,
    output logic      [DST_W-1:0]  headDst,
    output WbSelT                  headWbSel,
    output LoadTypeT               headLoadType,
    output logic                   headRegWr,
    output logic      [DATA_W-1:0] headDmOut,
    output logic                   creditReturn
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // entry storage, one array per field
    logic [DATA_W-1:0] aluOutMem   [DEPTH];
    logic [DATA_W-1:0] pcMem       [DEPTH];
    logic [DATA_W-1:0] outBMem     [DEPTH];
    logic [DST_W-1:0]  dstMem      [DEPTH];
    WbSelT             wbSelMem    [DEPTH];
    LoadTypeT          loadTypeMem [DEPTH];
    logic              regWrMem    [DEPTH];
    logic [DATA_W-1:0] dmOutMem    [DEPTH];

    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic             doPush;
    logic             doPop;

    // flush wins over both ends
    assign doPush = push && !mem2Flush;
    assign doPop  = pop && headValid && !mem2Flush;

    // one credit back per retired entry
    assign creditReturn = doPop;

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rstN || mem2Flush) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            // push and pop together leave count alone
            count <= count + CNT_W'(doPush) - CNT_W'(doPop);
        end
    end

    // write the tail slot
    always_ff @(posedge clk) begin
        if (doPush) begin
            aluOutMem[wrPtr]   <= pushAluOut;
            pcMem[wrPtr]       <= pushPc;
            outBMem[wrPtr]     <= pushOutB;
            dstMem[wrPtr]      <= pushDst;
            wbSelMem[wrPtr]    <= pushWbSel;
            loadTypeMem[wrPtr] <= pushLoadType;
            regWrMem[wrPtr]    <= pushRegWr;
            dmOutMem[wrPtr]    <= pushDmOut;
        end
    end

    // head view
    assign headValid    = (count != '0);
    assign headAluOut   = aluOutMem[rdPtr];
    assign headPc       = pcMem[rdPtr];
    assign headOutB     = outBMem[rdPtr];
    assign headDst      = dstMem[rdPtr];
    assign headWbSel    = wbSelMem[rdPtr];
    assign headLoadType = loadTypeMem[rdPtr];
    assign headRegWr    = regWrMem[rdPtr];
    assign headDmOut    = dmOutMem[rdPtr];

endmodule

`default_nettype wire

// File: source/mem2Writeback.sv
`timescale 1ns/10ps
`default_nettype none

// consumer, load extension, result select, regfile write
module mem2Writeback import mem2Pkg::*; (
    input  wire logic              mem2Wr,
    input  wire logic              mem2Flush,
    input  wire logic              headValid,
    input  wire logic [DATA_W-1:0] headAluOut,
    input  wire logic [DATA_W-1:0] headPc,
    input  wire logic [DATA_W-1:0] headOutB,
    input  wire logic [DST_W-1:0]  headDst,
    input  wire WbSelT             headWbSel,
    input  wire LoadTypeT          headLoadType,
    input  wire logic              headRegWr,
    input  wire logic [DATA_W-1:0] headDmOut,
    output logic                   pop,
    output logic                   wbEn,
    output logic      [DST_W-1:0]  wbDst,
    output logic      [DATA_W-1:0] wbData,
    output logic      [DATA_W-1:0] mem2Result,
    output logic      [DST_W-1:0]  mem2Dst,
    output logic                   mem2RegWr
);

    logic [7:0]        ldByte;
    logic [15:0]       ldHalf;
    logic [DATA_W-1:0] ldData;
    logic [DATA_W-1:0] result;

    // little endian lane pick
    always_comb begin
        case (headAluOut[1:0])
            2'd0:    ldByte = headDmOut[7:0];
            2'd1:    ldByte = headDmOut[15:8];
            2'd2:    ldByte = headDmOut[23:16];
            default: ldByte = headDmOut[31:24];
        endcase
        ldHalf = headAluOut[1] ? headDmOut[31:16] : headDmOut[15:0];
    end

    // sign or zero extension
    always_comb begin
        case (headLoadType)
            LD_B:    ldData = {{(DATA_W - 8){ldByte[7]}}, ldByte};
            LD_BU:   ldData = {{(DATA_W - 8){1'b0}}, ldByte};
            LD_H:    ldData = {{(DATA_W - 16){ldHalf[15]}}, ldHalf};
            LD_HU:   ldData = {{(DATA_W - 16){1'b0}}, ldHalf};
            default: ldData = headDmOut;
        endcase
    end

    // writeback source
    always_comb begin
        case (headWbSel)
            // link address skips the delay slot
            WB_PC8:  result = headPc + DATA_W'(8);
            WB_ALU:  result = headAluOut;
            WB_OUTB: result = headOutB;
            default: result = ldData;
        endcase
    end

    // retire only when the stage is enabled
    assign pop  = headValid && mem2Wr && !mem2Flush;
    assign wbEn = pop && headRegWr;

    assign wbDst  = headDst;
    assign wbData = result;

    // bypass view, valid even while stalled
    assign mem2Result = result;
    assign mem2Dst    = headDst;
    assign mem2RegWr  = headValid && headRegWr;

endmodule

`default_nettype wire

// File: source/memIssue.sv
`timescale 1ns/10ps
`default_nettype none

// producer side, credit counter plus one stage of metadata
module memIssue import mem2Pkg::*; #(
    parameter int DEPTH = 4
) (
    input  wire logic              clk,
    input  wire logic              rstN,
    input  wire logic              mem2Flush,
    input  wire logic              inValid,
    input  wire logic [DATA_W-1:0] inAluOut,
    input  wire logic [DATA_W-1:0] inPc,
    input  wire logic [DATA_W-1:0] inOutB,
    input  wire logic [DST_W-1:0]  inDst,
    input  wire WbSelT             inWbSel,
    input  wire LoadTypeT          inLoadType,
    input  wire logic              inRegWr,
    input  wire logic              inStore,
    input  wire logic              creditReturn,
    input  wire logic [DATA_W-1:0] ramRdata,
    output logic                   inReady,
    output logic                   ramEn,
    output logic                   ramWe,
    output logic      [ADDR_W-1:0] ramAddr,
    output logic      [DATA_W-1:0] ramWdata,
    output logic                   push,
    output logic      [DATA_W-1:0] pushAluOut,
    output logic      [DATA_W-1:0] pushPc,
    output logic      [DATA_W-1:0] pushOutB,
    output logic      [DST_W-1:0]  pushDst,
    output WbSelT                  pushWbSel,
    output LoadTypeT               pushLoadType,
    output logic                   pushRegWr,
    output logic      [DATA_W-1:0] pushDmOut
);

    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [CNT_W-1:0] credits;
    logic             accept;
    logic             stageValid;

    // no credit, no take; flush also blocks this cycle
    assign inReady = (credits != '0) && !mem2Flush;
    assign accept  = inValid && inReady;

    // memory access launched straight from the upstream fields
    assign ramEn    = accept;
    assign ramWe    = inStore;
    assign ramAddr  = inAluOut;
    assign ramWdata = inOutB;

    // spend on accept, refund on pop, refill on flush
    always_ff @(posedge clk) begin
        if (!rstN || mem2Flush) begin
            credits <= CNT_W'(DEPTH);
        end else begin
            credits <= credits + CNT_W'(creditReturn) - CNT_W'(accept);
        end
    end

    // one cycle valid, lines up with the ram read latency
    always_ff @(posedge clk) begin
        if (!rstN) begin
            stageValid <= 1'b0;
        end else begin
            stageValid <= accept;
        end
    end

    // payload only, captured with the access
    always_ff @(posedge clk) begin
        if (accept) begin
            pushAluOut   <= inAluOut;
            pushPc       <= inPc;
            pushOutB     <= inOutB;
            pushDst      <= inDst;
            pushWbSel    <= inWbSel;
            pushLoadType <= inLoadType;
            pushRegWr    <= inRegWr;
        end
    end

    // a flush in the push cycle drops the pending op
    assign push      = stageValid && !mem2Flush;
    // read data arrives exactly now
    assign pushDmOut = ramRdata;

endmodule

`default_nettype wire

// File: source/topMem2.sv
`timescale 1ns/10ps
`default_nettype none

// MEM2 stage top, issue -> ram -> queue -> writeback
module topMem2 import mem2Pkg::*; #(
    parameter int DEPTH     = 4,
    parameter int RAM_WORDS = 256
) (
    input  wire logic              clk,
    input  wire logic              rstN,
    input  wire logic              mem2Flush,
    input  wire logic              mem2Wr,
    input  wire logic              inValid,
    input  wire logic [DATA_W-1:0] inAluOut,
    input  wire logic [DATA_W-1:0] inPc,
    input  wire logic [DATA_W-1:0] inOutB,
    input  wire logic [DST_W-1:0]  inDst,
    input  wire WbSelT             inWbSel,
    input  wire LoadTypeT          inLoadType,
    input  wire logic              inRegWr,
    input  wire logic              inStore,
    output logic                   inReady,
    output logic                   wbEn,
    output logic      [DST_W-1:0]  wbDst,
    output logic      [DATA_W-1:0] wbData,
    output logic      [DATA_W-1:0] mem2Result,
    output logic      [DST_W-1:0]  mem2Dst,
    output logic                   mem2RegWr
);

    // ram port
    logic              ramEn;
    logic              ramWe;
    logic [ADDR_W-1:0] ramAddr;
    logic [DATA_W-1:0] ramWdata;
    logic [DATA_W-1:0] ramRdata;

    // issue to queue
    logic              push;
    logic [DATA_W-1:0] pushAluOut;
    logic [DATA_W-1:0] pushPc;
    logic [DATA_W-1:0] pushOutB;
    logic [DST_W-1:0]  pushDst;
    WbSelT             pushWbSel;
    LoadTypeT          pushLoadType;
    logic              pushRegWr;
    logic [DATA_W-1:0] pushDmOut;
    logic              creditReturn;

    // queue head to writeback
    logic              headValid;
    logic [DATA_W-1:0] headAluOut;
    logic [DATA_W-1:0] headPc;
    logic [DATA_W-1:0] headOutB;
    logic [DST_W-1:0]  headDst;
    WbSelT             headWbSel;
    LoadTypeT          headLoadType;
    logic              headRegWr;
    logic [DATA_W-1:0] headDmOut;
    logic              pop;

    memIssue #(.DEPTH(DEPTH)) u_memIssue (
        .clk, .rstN, .mem2Flush, .inValid, .inAluOut, .inPc, .inOutB, .inDst,
        .inWbSel, .inLoadType, .inRegWr, .inStore, .creditReturn, .ramRdata,
        .inReady, .ramEn, .ramWe, .ramAddr, .ramWdata, .push, .pushAluOut,
        .pushPc, .pushOutB, .pushDst, .pushWbSel, .pushLoadType, .pushRegWr,
        .pushDmOut
    );

    dataRam #(.RAM_WORDS(RAM_WORDS)) u_dataRam (
        .clk, .rstN, .ramEn, .ramWe, .ramAddr, .ramWdata, .ramRdata
    );

    mem2Queue #(.DEPTH(DEPTH)) u_mem2Queue (
        .clk, .rstN, .mem2Flush, .push, .pushAluOut, .pushPc, .pushOutB,
        .pushDst, .pushWbSel, .pushLoadType, .pushRegWr, .pushDmOut, .pop,
        .headValid, .headAluOut, .headPc, .headOutB, .headDst, .headWbSel,
        .headLoadType, .headRegWr, .headDmOut, .creditReturn
    );

    mem2Writeback u_mem2Writeback (
        .mem2Wr, .mem2Flush, .headValid, .headAluOut, .headPc, .headOutB,
        .headDst, .headWbSel, .headLoadType, .headRegWr, .headDmOut, .pop,
        .wbEn, .wbDst, .wbData, .mem2Result, .mem2Dst, .mem2RegWr
    );

endmodule

`default_nettype wire

// File: tests/tbTopMem2.sv
`timescale 1ns/10ps
`default_nettype none

module tbTopMem2 import mem2Pkg::*; ();

    localparam int DEPTH = 4;
    // fill, word, extend, select, backpressure, flush
    localparam int NUM_OPS = 256 + 32 + 32 + 24 + DEPTH + 2 * DEPTH;

    logic              clk = 1'b0;
    logic              rstN = 1'b0;
    logic              mem2Flush = 1'b0;
    logic              mem2Wr = 1'b0;
    logic              inValid = 1'b0;
    logic [DATA_W-1:0] inAluOut = '0;
    logic [DATA_W-1:0] inPc = '0;
    logic [DATA_W-1:0] inOutB = '0;
    logic [DST_W-1:0]  inDst = '0;
    WbSelT             inWbSel = WB_ALU;
    LoadTypeT          inLoadType = LD_W;
    logic              inRegWr = 1'b0;
    logic              inStore = 1'b0;
    logic              inReady;
    logic              wbEn;
    logic [DST_W-1:0]  wbDst;
    logic [DATA_W-1:0] wbData;
    logic [DATA_W-1:0] mem2Result;
    logic [DST_W-1:0]  mem2Dst;
    logic              mem2RegWr;

    // reference model state
    logic [31:0] memImg [256];
    logic [4:0]  expDst [$];
    logic [31:0] expData [$];
    integer      seed = 32'h7b6f_2a3b;
    int          errors = 0;
    int          checks = 0;
    logic        randStall = 1'b0;
    string       testName = "reset";
    LoadTypeT    ldList [4] = '{LD_B, LD_BU, LD_H, LD_HU};
    WbSelT       selList [3] = '{WB_PC8, WB_ALU, WB_OUTB};

    topMem2 #(.DEPTH(DEPTH), .RAM_WORDS(256)) u_topMem2 (
        .clk, .rstN, .mem2Flush, .mem2Wr, .inValid, .inAluOut, .inPc, .inOutB,
        .inDst, .inWbSel, .inLoadType, .inRegWr, .inStore, .inReady, .wbEn,
        .wbDst, .wbData, .mem2Result, .mem2Dst, .mem2RegWr
    );

    always #20 clk = ~clk;

    // result per the select and little endian extension rules
    function automatic logic [31:0] expectedResult(input WbSelT sel, input LoadTypeT lt,
            input logic [31:0] pc, input logic [31:0] alu, input logic [31:0] outB,
            input logic [31:0] word);
        logic [7:0]  byteLane;
        logic [15:0] halfLane;
        logic [31:0] loaded;
        byteLane = word[8 * alu[1:0] +: 8];
        halfLane = alu[1] ? word[31:16] : word[15:0];
        case (lt)
            LD_B:    loaded = {{24{byteLane[7]}}, byteLane};
            LD_BU:   loaded = {24'd0, byteLane};
            LD_H:    loaded = {{16{halfLane[15]}}, halfLane};
            LD_HU:   loaded = {16'd0, halfLane};
            default: loaded = word;
        endcase
        case (sel)
            WB_PC8:  expectedResult = pc + 32'd8;
            WB_ALU:  expectedResult = alu;
            WB_OUTB: expectedResult = outB;
            default: expectedResult = loaded;
        endcase
    endfunction

    task automatic checkValue(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("FAIL %s %s expected %h actual %h", testName, what, exp, act);
        end
    endtask

    // hold the op until taken, then update the model
    task automatic issueOp(input logic store, input logic regWr, input WbSelT sel,
            input LoadTypeT lt, input logic [31:0] alu, input logic [31:0] pc,
            input logic [31:0] outB, input logic [4:0] dst, output int waited);
        logic taken;
        waited = 0;
        forever begin
            @(negedge clk);
            // roughly one stall cycle in four
            if (randStall) begin
                mem2Wr = (($random(seed) & 3) != 0);
            end
            inValid = 1'b1;
            inStore = store;
            inRegWr = regWr;
            inWbSel = sel;
            inLoadType = lt;
            inAluOut = alu;
            inPc = pc;
            inOutB = outB;
            inDst = dst;
            // ready is settled mid cycle, taken at the coming edge
            taken = inReady;
            @(posedge clk);
            if (taken) begin
                break;
            end
            waited++;
        end
        if (store) begin
            memImg[alu[9:2]] = outB;
        end
        if (regWr) begin
            expDst.push_back(dst);
            expData.push_back(expectedResult(sel, lt, pc, alu, outB, memImg[alu[9:2]]));
        end
    endtask

    // let everything outstanding retire
    task automatic drain();
        @(negedge clk);
        inValid = 1'b0;
        mem2Wr = 1'b1;
        while (expData.size() != 0) begin
            @(negedge clk);
        end
        // non-writing ops may still sit behind the last checked one
        repeat (DEPTH + 2) @(negedge clk);
    endtask

    // writeback compare against the model head
    always @(posedge clk) begin
        if (rstN && wbEn) begin
            if (expData.size() == 0) begin
                errors++;
                $display("unexpected register write to r%0d in test %s", wbDst, testName);
            end else begin
                checkValue("wbDst", expDst.pop_front(), wbDst);
                checkValue("wbData", expData.pop_front(), wbData);
            end
        end
    end

    // watchdog sized from the planned op count
    initial begin
        #((NUM_OPS * 20 + 8) * 40);
        $display("run timed out before all tests finished");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int          waited;
        logic [31:0] addr;
        @(negedge clk);
        // writeback enabled inside reset, queue must still stay silent
        mem2Wr = 1'b1;
        repeat (7) @(negedge clk);
        rstN = 1'b1;

        // every word written once, so no load reads an unwritten word
        testName = "fill";
        for (int i = 0; i < 256; i++) begin
            issueOp(1'b1, 1'b0, WB_ALU, LD_W, i * 4, 32'd0, $random(seed), 5'd0, waited);
        end
        drain();

        testName = "word";
        randStall = 1'b1;
        for (int i = 0; i < 16; i++) begin
            addr = $random(seed);
            issueOp(1'b1, 1'b0, WB_ALU, LD_W, addr, 32'd0, $random(seed), 5'd0, waited);
            issueOp(1'b0, 1'b1, WB_MEM, LD_W, addr, $random(seed), $random(seed),
                5'($random(seed)), waited);
        end

        // each extension at each byte offset, twice
        testName = "extend";
        for (int i = 0; i < 32; i++) begin
            addr = $random(seed);
            addr[1:0] = i[1:0];
            issueOp(1'b0, 1'b1, WB_MEM, ldList[(i / 4) % 4], addr, $random(seed),
                $random(seed), 5'($random(seed)), waited);
        end

        testName = "select";
        for (int i = 0; i < 24; i++) begin
            issueOp(1'b0, 1'($random(seed)), selList[i % 3], LD_W, $random(seed),
                $random(seed), $random(seed), 5'($random(seed)), waited);
        end
        randStall = 1'b0;
        drain();

        testName = "backpressure";
        mem2Wr = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            issueOp(1'b0, 1'b1, WB_ALU, LD_W, $random(seed), 32'd0, 32'd0, 5'(i + 1), waited);
            checkValue("accept delay", 32'd0, waited);
        end
        @(negedge clk);
        inValid = 1'b0;
        checkValue("inReady", 32'd0, inReady);
        // stalled head is still visible for forwarding
        checkValue("mem2Result", expData[0], mem2Result);
        checkValue("mem2Dst", expDst[0], mem2Dst);
        checkValue("mem2RegWr", 32'd1, mem2RegWr);
        repeat (3) begin
            @(negedge clk);
            checkValue("inReady", 32'd0, inReady);
        end
        drain();

        testName = "flush";
        mem2Wr = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            issueOp(1'b0, 1'b1, WB_ALU, LD_W, $random(seed), 32'd0, 32'd0, 5'(i + 8), waited);
        end
        @(negedge clk);
        inValid = 1'b0;
        mem2Flush = 1'b1;
        @(posedge clk);
        // outstanding ops are dropped
        expDst.delete();
        expData.delete();
        @(negedge clk);
        mem2Flush = 1'b0;
        mem2Wr = 1'b1;
        @(negedge clk);
        checkValue("inReady", 32'd1, inReady);
        for (int i = 0; i < DEPTH; i++) begin
            issueOp(1'b0, 1'b1, WB_OUTB, LD_W, 32'd0, 32'd0, $random(seed), 5'(i + 16), waited);
            checkValue("accept delay", 32'd0, waited);
        end
        drain();

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/topMem2_checker.sv
`timescale 1ns/10ps
`default_nettype none

// protocol checks on the MEM2 stage internals
module topMem2_checker #(
    parameter int DEPTH = 4
) (
    input wire logic                         clk,
    input wire logic                         rstN,
    input wire logic                         wbEn,
    input wire logic                         push,
    input wire logic                         pop,
    input wire logic                         headValid,
    input wire logic [$clog2(DEPTH + 1)-1:0] credits,
    input wire logic [$clog2(DEPTH + 1)-1:0] count
);

    // no register file write during reset
    wbEnInReset: assert property (@(posedge clk) !rstN |-> !wbEn)
        else $error("wbEn high while reset is asserted");

    // queue never overflows
    pushWhenFull: assert property (@(posedge clk) disable iff (!rstN)
        push |-> (int'(count) < DEPTH))
        else $error("push into a full MEM2 queue");

    // credits, entries and the pending push share DEPTH slots
    creditBudget: assert property (@(posedge clk) disable iff (!rstN)
        (int'(credits) + int'(count) + int'(push)) <= DEPTH)
        else $error("credits plus queue entries exceed DEPTH");

    popOnEmpty: assert property (@(posedge clk) disable iff (!rstN)
        pop |-> headValid)
        else $error("pop without a valid head");

endmodule

bind topMem2 topMem2_checker #(.DEPTH(DEPTH)) u_topMem2Checker (
    .clk(clk),
    .rstN(rstN),
    .wbEn(wbEn),
    .push(push),
    .pop(pop),
    .headValid(headValid),
    .credits(u_memIssue.credits),
    .count(u_mem2Queue.count)
);

`default_nettype wire
